/* hdl/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// --------------------
// tank adc words
// --------------------
`define ADC_W            14     // two's complement from the adc
`define ADC_FS_POS       8191   // +full scale, 14'h1fff
`define ADC_FS_NEG       8192   // -full scale, 14'h2000
`define DAC_OFFSET       8191   // shifts the copy to offset binary

// --------------------
// dead time, in ADA_DCO cycles
// --------------------
`define DT_CYC_0         10     // sel 2'b00
`define DT_CYC_1         20     // sel 2'b10
`define DT_CYC_2         40     // sel 2'b01
`define DT_CYC_3         60     // sel 2'b11
`define DT_CNT_W         6      // must hold DT_CYC_3

// --------------------
// start-up and switch timing
// --------------------
`define STARTUP_PRESCALE 4      // clocks per start-up count
`define BOOT_ON_COUNT    10     // leave bootstrap above this
`define BOOT_VG_COUNT    16     // reach run above this
`define DEBOUNCE_CYCLES  32     // stable cycles before the enable moves

`endif

/* hdl/bridge_pkg.sv */
`include "bridge_defs.svh"

package bridge_pkg;

   // conditioned tank sample pair
   // a is the tank voltage channel, b the tank current channel
   typedef struct packed {
      logic signed [`ADC_W-1:0] a;   // channel A, saturated and inverted
      logic signed [`ADC_W-1:0] b;   // channel B, inverted
   } adc_sample_t;

   // gate word seen per transistor
   // leg 1 is m1/m3, leg 2 is m2/m4
   typedef struct packed {
      logic m4;   // leg 2 low side
      logic m3;   // leg 1 low side
      logic m2;   // leg 2 high side
      logic m1;   // leg 1 high side
   } gate_legs_t;

   // same four bits, flat or per leg
   typedef union packed {
      logic [3:0] bits;   // bit 0 is m1 .. bit 3 is m4
      gate_legs_t legs;
   } gate_u;

   // bridge start-up phase
   typedef enum logic [1:0] {
      PH_OFF   = 2'b00,   // all gates off
      PH_BOOT  = 2'b01,   // low sides on, bootstrap caps charge
      PH_FORCE = 2'b10,   // m1 + m4, forces the first tank state
      PH_RUN   = 2'b11    // dead-timed commands go through
   } bridge_phase_t;

endpackage

/* hdl/adc_capture.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module adc_capture (
   input  logic                     ADA_DCO,
   input  logic                     i_arst_n,
   input  logic signed [`ADC_W-1:0] i_ada_data,  // tank voltage, raw
   input  logic                     i_ada_or,    // channel A over-range flag
   input  logic signed [`ADC_W-1:0] i_adb_data,  // tank current, raw
   output bridge_pkg::adc_sample_t  o_sample,
   output logic [`ADC_W-1:0]        o_dac_a,
   output logic [`ADC_W-1:0]        o_dac_b
);

   localparam int W = `ADC_W;
   localparam logic [W-1:0] FS_POS  = W'(`ADC_FS_POS);
   localparam logic [W-1:0] FS_NEG  = W'(`ADC_FS_NEG);
   localparam logic [W-1:0] DAC_OFS = W'(`DAC_OFFSET);

   logic [W-1:0] neg_a;   // polarity-corrected A, before saturation
   logic [W-1:0] neg_b;   // polarity-corrected B
   logic         a_at_neg_fs;

   // sensing is wired inverted on the board, so flip both channels
   assign neg_a = ~i_ada_data + W'(1);   // wraps mod 2^14
   assign neg_b = ~i_adb_data + W'(1);

   // -full scale flagged as over-range has to land on +full scale
   assign a_at_neg_fs = ($unsigned(i_ada_data) == FS_NEG);

   // --------------------
   // sample registers
   // --------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_sample <= '0;
         o_dac_a  <= '0;
         o_dac_b  <= '0;
      end else begin
         // channel A saturates on over-range
         if (i_ada_or) begin
            o_sample.a <= a_at_neg_fs ? FS_POS : FS_NEG;   // clamp to opposite rail
         end else begin
            o_sample.a <= neg_a;
         end
         o_sample.b <= neg_b;   // no over-range handling on B

         // DAC copies are offset binary, over-range ignored
         o_dac_a <= neg_a + DAC_OFS;
         o_dac_b <= neg_b + DAC_OFS;
      end
   end

endmodule

/* hdl/enable_debounce.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module enable_debounce (
   input  logic ADA_DCO,
   input  logic i_arst_n,
   input  logic i_sw,      // raw enable switch
   output logic o_level    // accepted switch level
);

   localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

   logic [CNT_W-1:0] stable_cnt;   // cycles the switch has disagreed with o_level
   logic             differs;

   assign differs = (i_sw != o_level);

   // --------------------
   // stability counter
   // --------------------
   // counts only while the switch differs from the accepted level,
   // any bounce back clears it
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stable_cnt <= '0;
         o_level    <= 1'b0;   // converter disabled out of reset
      end else begin
         if (!differs) begin
            stable_cnt <= '0;   // bounce or settled
         end else if (stable_cnt == CNT_LAST) begin
            // held long enough, take the new level
            o_level    <= i_sw;
            stable_cnt <= '0;
         end else begin
            stable_cnt <= stable_cnt + CNT_W'(1);
         end
      end
   end

endmodule

/* hdl/startup_seq.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module startup_seq (
   input  logic                      ADA_DCO,
   input  logic                      i_arst_n,
   input  logic                      i_enable,   // debounced converter enable
   output bridge_pkg::bridge_phase_t o_phase
);

   import bridge_pkg::*;

   localparam int PS_W = $clog2(`STARTUP_PRESCALE);
   localparam logic [PS_W-1:0] PS_LAST = PS_W'(`STARTUP_PRESCALE - 1);

   logic [PS_W-1:0] presc;      // divides the clock down to start-up counts
   logic [7:0]      boot_cnt;   // start-up count
   logic            vg_ok;      // count past the forced-state window

   assign vg_ok = (boot_cnt > 8'(`BOOT_VG_COUNT));

   // --------------------
   // start-up counter
   // --------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         presc    <= '0;
         boot_cnt <= '0;
      end else if (!i_enable) begin
         presc    <= '0;   // restart from zero on the next enable
         boot_cnt <= '0;
      end else if (!vg_ok) begin
         if (presc == PS_LAST) begin
            presc    <= '0;
            boot_cnt <= boot_cnt + 8'd1;
         end else begin
            presc <= presc + PS_W'(1);
         end
      end
      // once running the count just holds
   end

   // phase decode, off wins whenever the enable is low
   always_comb begin
      if (!i_enable) o_phase = PH_OFF;
      else if (boot_cnt <= 8'(`BOOT_ON_COUNT)) o_phase = PH_BOOT;   // charge caps
      else if (!vg_ok) o_phase = PH_FORCE;
      else o_phase = PH_RUN;
   end

endmodule

/* hdl/dead_time_gen.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module dead_time_gen (
   input  logic              ADA_DCO,
   input  logic              i_arst_n,
   input  logic [1:0]        i_dt_sel,   // dead-time select
   input  bridge_pkg::gate_u i_cmd,      // raw gate commands
   output bridge_pkg::gate_u o_gate      // turn-on delayed commands
);

   localparam int CW = `DT_CNT_W;

   logic [CW-1:0] dt_cyc;        // selected dead time D
   logic [CW-1:0] on_cnt [4];    // one per transistor

   // --------------------
   // select decode
   // --------------------
   // note the swapped middle codes, 2'b10 is the shorter one
   always_comb begin
      case (i_dt_sel)
         2'b00:   dt_cyc = CW'(`DT_CYC_0);
         2'b10:   dt_cyc = CW'(`DT_CYC_1);
         2'b01:   dt_cyc = CW'(`DT_CYC_2);
         default: dt_cyc = CW'(`DT_CYC_3);   // 2'b11
      endcase
   end

   // --------------------
   // per-bit turn-on delay
   // --------------------
   // low command drops the gate after one register,
   // high command needs D cycles of count before the gate follows
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gate.bits <= '0;
         for (int i = 0; i < 4; i++) begin
            on_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (!i_cmd.bits[i]) begin
               on_cnt[i]      <= '0;     // turn-off is immediate
               o_gate.bits[i] <= 1'b0;
            end else if (on_cnt[i] >= dt_cyc) begin
               o_gate.bits[i] <= 1'b1;   // dead time elapsed, counter parks
            end else begin
               on_cnt[i] <= on_cnt[i] + CW'(1);
            end
         end
      end
   end

endmodule

/* hdl/gate_driver.sv */
`timescale 1ns/1ps

module gate_driver (
   input  logic                      ADA_DCO,
   input  logic                      i_arst_n,
   input  bridge_pkg::bridge_phase_t i_phase,
   input  bridge_pkg::gate_u         i_gate,   // dead-timed commands
   output bridge_pkg::gate_u         o_q       // gate pins
);

   import bridge_pkg::*;

   logic  shoot_thru;   // both switches of one leg requested
   gate_u q_nxt;

   // high and low side of the same leg must never be on together
   assign shoot_thru = (i_gate.legs.m1 & i_gate.legs.m3) |
                       (i_gate.legs.m2 & i_gate.legs.m4);

   // --------------------
   // pattern select
   // --------------------
   always_comb begin
      q_nxt.bits = 4'b0000;
      if (!shoot_thru) begin   // blank everything on a leg conflict
         case (i_phase)
            PH_BOOT: begin
               q_nxt.legs.m3 = 1'b1;   // low sides, charge bootstrap
               q_nxt.legs.m4 = 1'b1;
            end
            PH_FORCE: begin
               q_nxt.legs.m1 = 1'b1;   // diagonal pair, first tank state
               q_nxt.legs.m4 = 1'b1;
            end
            PH_RUN:  q_nxt = i_gate;
            default: q_nxt.bits = 4'b0000;   // PH_OFF
         endcase
      end
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) o_q <= '0;   // gates off
      else o_q <= q_nxt;
   end

endmodule

/* hdl/bridge_ctrl_top.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module bridge_ctrl_top (
   input  logic                     ADA_DCO,
   input  logic                     i_arst_n,
   // tank adcs
   input  logic signed [`ADC_W-1:0] i_ada_data,
   input  logic                     i_ada_or,
   input  logic signed [`ADC_W-1:0] i_adb_data,
   // user controls
   input  logic                     i_sw_enable,   // converter enable switch
   input  logic [1:0]               i_dt_sel,      // dead-time select
   // commands from the control law
   input  bridge_pkg::gate_u        i_gate_cmd,
   // outputs
   output bridge_pkg::adc_sample_t  o_sample,
   output logic [`ADC_W-1:0]        o_dac_a,
   output logic [`ADC_W-1:0]        o_dac_b,
   output bridge_pkg::gate_u        o_q            // m1..m4 gate pins
);

   import bridge_pkg::*;

   logic          enable;    // debounced switch
   bridge_phase_t phase;     // start-up phase
   gate_u         gate_dt;   // commands after dead time

   // --------------------
   // tank sensing
   // --------------------
   adc_capture u_adc_capture (
      .ADA_DCO    (ADA_DCO),
      .i_arst_n   (i_arst_n),
      .i_ada_data (i_ada_data),
      .i_ada_or   (i_ada_or),
      .i_adb_data (i_adb_data),   // B sampled on the A clock
      .o_sample   (o_sample),
      .o_dac_a    (o_dac_a),
      .o_dac_b    (o_dac_b)
   );

   // --------------------
   // enable and start-up
   // --------------------
   enable_debounce u_enable_debounce (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_sw     (i_sw_enable),
      .o_level  (enable)
   );

   startup_seq u_startup_seq (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_enable (enable),   // only reader of the enable
      .o_phase  (phase)
   );

   // --------------------
   // gate path
   // --------------------
   dead_time_gen u_dead_time_gen (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_dt_sel (i_dt_sel),
      .i_cmd    (i_gate_cmd),
      .o_gate   (gate_dt)
   );

   gate_driver u_gate_driver (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_phase  (phase),
      .i_gate   (gate_dt),
      .o_q      (o_q)         // interlocked and registered
   );

endmodule

/* bench/tb_bridge_model.svh */
// reference model of the bridge controller, stepped once per clock

// --------------------
// model state
// --------------------
logic [31:0]       lcg_state = 32'h33e8;
logic [`ADC_W-1:0] exp_a;
logic [`ADC_W-1:0] exp_b;
logic [`ADC_W-1:0] exp_dac_a;
logic [`ADC_W-1:0] exp_dac_b;
logic [3:0]        exp_q;        // gate pins after this edge
logic [3:0]        mdl_dt;       // dead-timed word, bit 0 = m1
int                mdl_on [4];   // turn-on counters
logic              mdl_level;    // debounced enable
int                mdl_db;       // cycles the switch disagreed
int                mdl_presc;
int                mdl_count;    // start-up count
int                n_checks = 0;
int                n_errors = 0;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic int rand_below(input int n);
   logic [31:0] r;
   r = lcg_next();
   return int'(r[30:8]) % n;   // low lcg bits are weak
endfunction

// select code to dead time, middle codes swapped
function automatic int dt_cycles(input logic [1:0] sel);
   case (sel)
      2'b00:   return `DT_CYC_0;
      2'b10:   return `DT_CYC_1;
      2'b01:   return `DT_CYC_2;
      default: return `DT_CYC_3;
   endcase
endfunction

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
   n_checks++;
   if (got !== exp) begin
      n_errors++;
      $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
   end
endtask

task automatic reset_model();
   exp_a     = '0;
   exp_b     = '0;
   exp_dac_a = '0;
   exp_dac_b = '0;
   exp_q     = 4'b0000;
   mdl_dt    = 4'b0000;
   mdl_level = 1'b0;
   mdl_db    = 0;
   mdl_presc = 0;
   mdl_count = 0;
   for (int i = 0; i < 4; i++) begin
      mdl_on[i] = 0;
   end
endtask

// one rising edge, with the inputs that were held over it
task automatic step_model();
   logic [`ADC_W-1:0] neg_a;
   logic [`ADC_W-1:0] neg_b;
   logic              shoot;
   bridge_phase_t     ph;
   int                d;

   // --------------------
   // adc channels
   // --------------------
   neg_a = -ada_data;   // mod 2^14
   neg_b = -adb_data;
   if (ada_or && ada_data == `ADC_W'(`ADC_FS_NEG)) exp_a = `ADC_W'(`ADC_FS_POS);
   else if (ada_or) exp_a = `ADC_W'(`ADC_FS_NEG);
   else exp_a = neg_a;
   exp_b     = neg_b;
   exp_dac_a = neg_a + `ADC_W'(`DAC_OFFSET);   // over-range ignored here
   exp_dac_b = neg_b + `ADC_W'(`DAC_OFFSET);

   // --------------------
   // gate rule, from the state before the edge
   // --------------------
   if (!mdl_level) ph = PH_OFF;
   else if (mdl_count <= `BOOT_ON_COUNT) ph = PH_BOOT;
   else if (mdl_count <= `BOOT_VG_COUNT) ph = PH_FORCE;
   else ph = PH_RUN;
   shoot = (mdl_dt[0] & mdl_dt[2]) | (mdl_dt[1] & mdl_dt[3]);   // m1+m3, m2+m4
   if (shoot || ph == PH_OFF) exp_q = 4'b0000;
   else if (ph == PH_BOOT) exp_q = 4'b1100;    // m4 m3
   else if (ph == PH_FORCE) exp_q = 4'b1001;   // m4 m1
   else exp_q = mdl_dt;

   // dead time per bit
   d = dt_cycles(dt_sel);
   for (int i = 0; i < 4; i++) begin
      if (!gate_cmd.bits[i]) begin
         mdl_on[i] = 0;
         mdl_dt[i] = 1'b0;
      end else if (mdl_on[i] >= d) begin
         mdl_dt[i] = 1'b1;
      end else begin
         mdl_on[i]++;
      end
   end

   // start-up count runs on the old enable
   if (!mdl_level) begin
      mdl_presc = 0;
      mdl_count = 0;
   end else if (mdl_count <= `BOOT_VG_COUNT) begin
      mdl_presc++;
      if (mdl_presc == `STARTUP_PRESCALE) begin
         mdl_presc = 0;
         mdl_count++;
      end
   end

   // debounce, any agreement restarts the run
   if (sw_enable != mdl_level) begin
      mdl_db++;
      if (mdl_db == `DEBOUNCE_CYCLES) begin
         mdl_level = sw_enable;
         mdl_db    = 0;
      end
   end else begin
      mdl_db = 0;
   end
endtask

/* bench/tb_bridge_ctrl.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module tb_bridge_ctrl;

   import bridge_pkg::*;

   localparam int DB      = `DEBOUNCE_CYCLES;
   localparam int T_BOOT  = DB + 1;   // switch settled to bootstrap pattern
   localparam int T_FORCE = (`BOOT_ON_COUNT + 1) * `STARTUP_PRESCALE;
   localparam int T_RUN   = (`BOOT_VG_COUNT - `BOOT_ON_COUNT) * `STARTUP_PRESCALE;

   logic                     ada_dco = 1'b0;
   logic                     arst_n;
   logic signed [`ADC_W-1:0] ada_data;
   logic                     ada_or;
   logic signed [`ADC_W-1:0] adb_data;
   logic                     sw_enable;
   logic [1:0]               dt_sel;
   gate_u                    gate_cmd;
   adc_sample_t              sample;
   logic [`ADC_W-1:0]        dac_a;
   logic [`ADC_W-1:0]        dac_b;
   gate_u                    q;
   int                       err_mark = 0;   // errors before the current test
   int                       zeros_dut;
   int                       zeros_mdl;

`include "tb_bridge_model.svh"

   bridge_ctrl_top uut (
      .ADA_DCO     (ada_dco),
      .i_arst_n    (arst_n),
      .i_ada_data  (ada_data),
      .i_ada_or    (ada_or),
      .i_adb_data  (adb_data),
      .i_sw_enable (sw_enable),
      .i_dt_sel    (dt_sel),
      .i_gate_cmd  (gate_cmd),
      .o_sample    (sample),
      .o_dac_a     (dac_a),
      .o_dac_b     (dac_b),
      .o_q         (q)
   );

   initial begin
      forever #20 ada_dco = ~ada_dco;   // 40 ns
   end

   // --------------------
   // helpers
   // --------------------
   // step the model on the falling edge and compare before the caller drives
   task automatic advance_cycle();
      @(negedge ada_dco);
      if (!arst_n) reset_model();
      else step_model();
      compare_value("o_q", q.bits, exp_q);
      compare_value("o_sample.a", $unsigned(sample.a), exp_a);   // no sign extension
      compare_value("o_sample.b", $unsigned(sample.b), exp_b);
      compare_value("o_dac_a", dac_a, exp_dac_a);
      compare_value("o_dac_b", dac_b, exp_dac_b);
   endtask

   task automatic hold_cycles(input int n);
      repeat (n) advance_cycle();
   endtask

   task automatic wait_for_gate(input logic [3:0] target, input int limit, output int cycles);
      int n;
      n = 0;
      do begin
         advance_cycle();
         n++;
      end while (q.bits !== target && n < limit);
      if (q.bits !== target) begin
         n_errors++;
         $display("timeout: o_q never showed %b within %0d cycles", target, limit);
         cycles = -1;
      end else begin
         cycles = n;
      end
   endtask

   // bounces shorter than the debounce before the switch is held on
   task automatic run_startup();
      int c;
      repeat (3) begin
         sw_enable = 1'b1;
         hold_cycles(1 + rand_below(DB - 1));
         sw_enable = 1'b0;
         hold_cycles(1 + rand_below(8));
      end
      sw_enable = 1'b1;
      wait_for_gate(4'b1100, 4 * T_BOOT, c);
      compare_value("cycles to bootstrap", c, T_BOOT);
      wait_for_gate(4'b1001, 4 * T_FORCE, c);
      compare_value("cycles to forced state", c, T_FORCE);
      wait_for_gate(gate_cmd.bits, 4 * T_RUN, c);
      compare_value("cycles to run", c, T_RUN);
   endtask

   // at most one switch per leg
   function automatic logic [3:0] legal_cmd(input logic [31:0] r);
      logic [3:0] c;
      c = 4'b0000;
      if (r[9:8] == 2'd1) c[0] = 1'b1;         // m1
      else if (r[9:8] == 2'd2) c[2] = 1'b1;    // m3
      if (r[11:10] == 2'd1) c[1] = 1'b1;       // m2
      else if (r[11:10] == 2'd2) c[3] = 1'b1;  // m4
      return c;
   endfunction

   task automatic report_test(input string name);
      if (n_errors == err_mark) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, n_errors - err_mark);
      err_mark = n_errors;
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin
      int d;
      arst_n        = 1'b0;
      ada_data      = '0;
      ada_or        = 1'b0;
      adb_data      = '0;
      sw_enable     = 1'b0;
      dt_sel        = 2'b00;
      gate_cmd.bits = 4'b0000;
      hold_cycles(10);
      arst_n = 1'b1;

      // 1 reset values and gates off while disabled
      compare_value("o_q", q.bits, 0);
      compare_value("o_sample", sample, 0);
      compare_value("o_dac_a", dac_a, 0);
      compare_value("o_dac_b", dac_b, 0);
      repeat (50) begin
         gate_cmd.bits = 4'(rand_below(16));
         dt_sel        = 2'(rand_below(4));
         advance_cycle();
         compare_value("o_q while disabled", q.bits, 0);
      end
      report_test("1 reset");

      // 2 adc capture with forced full-scale codes
      for (int i = 0; i < 300; i++) begin
         if (i % 10 == 0) begin
            ada_data = `ADC_W'(`ADC_FS_NEG);
            ada_or   = 1'b1;
         end else if (i % 10 == 5) begin
            ada_data = `ADC_W'(`ADC_FS_NEG);
            ada_or   = 1'b0;
         end else begin
            ada_data = `ADC_W'(rand_below(1 << `ADC_W));
            ada_or   = (rand_below(4) == 0);
         end
         adb_data = `ADC_W'(rand_below(1 << `ADC_W));
         advance_cycle();
      end
      report_test("2 adc capture");

      // 3 start-up order and timing
      gate_cmd.bits = 4'b0110;   // legal diagonal m2 m3
      dt_sel        = 2'b00;
      run_startup();
      report_test("3 start-up");

      // 4 dead time for each select code
      for (int s = 0; s < 4; s++) begin
         gate_cmd.bits = 4'b0000;
         dt_sel        = 2'(s);
         d             = dt_cycles(dt_sel);
         hold_cycles(3);
         repeat (12) begin
            gate_cmd.bits = legal_cmd(lcg_next());
            hold_cycles(1 + rand_below(2 * d + 8));   // some runs shorter than d
         end
      end
      report_test("4 dead time");

      // 5 shoot-through blanking on leg 1 then leg 2
      dt_sel    = 2'b00;
      zeros_dut = 0;
      zeros_mdl = 0;
      for (int leg = 0; leg < 2; leg++) begin
         gate_cmd.bits = (leg == 0) ? 4'b0001 : 4'b1000;   // one side alone first
         hold_cycles(20);
         gate_cmd.bits = (leg == 0) ? 4'b0101 : 4'b1010;   // add the other side
         repeat (30) begin
            advance_cycle();
            if (q.bits == 4'b0000) zeros_dut++;
            if (exp_q == 4'b0000) zeros_mdl++;
         end
         compare_value("o_q blanked", q.bits, 0);
         gate_cmd.bits = 4'b0000;
         hold_cycles(5);
      end
      compare_value("blanked cycles", zeros_dut, zeros_mdl);
      report_test("5 interlock");

      // 6 release and a fresh start-up from count zero
      gate_cmd.bits = 4'b0110;
      hold_cycles(15);
      compare_value("o_q before release", q.bits, 4'b0110);
      sw_enable = 1'b0;
      wait_for_gate(4'b0000, 4 * T_BOOT, d);
      compare_value("cycles to off", d, T_BOOT);
      hold_cycles(20);
      run_startup();
      hold_cycles(5);
      report_test("6 disable and restart");

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+hdl
+incdir+bench
hdl/bridge_pkg.sv
hdl/adc_capture.sv
hdl/enable_debounce.sv
hdl/startup_seq.sv
hdl/dead_time_gen.sv
hdl/gate_driver.sv
hdl/bridge_ctrl_top.sv
bench/tb_bridge_ctrl.sv

/* Bender.yml */
package:
  name: bridge_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bridge_pkg.sv
      - hdl/adc_capture.sv
      - hdl/enable_debounce.sv
      - hdl/startup_seq.sv
      - hdl/dead_time_gen.sv
      - hdl/gate_driver.sv
      - hdl/bridge_ctrl_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - bench
    files:
      - bench/tb_bridge_ctrl.sv
